// ==== src/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    // bus and memory widths
    typedef logic [7:0]  byte_t;
    typedef logic [13:0] vram_addr_t;

    // frame position
    typedef logic [8:0]  scanline_t;
    typedef logic [8:0]  cycle_t;

    // ntsc color code as stored in palette ram
    typedef logic [5:0]  color_t;

    // bit 4 picks the sprite half, never set by the background path
    typedef logic [4:0]  pal_index_t;

    // {attribute[1:0], pattern[1:0]}
    typedef logic [3:0]  bg_pixel_t;

    typedef logic [7:0]  scroll_t;

    // cpu visible register map, offsets from 0x2000
    typedef enum logic [2:0] {
        REG_CTRL     = 3'd0,
        REG_MASK     = 3'd1,
        REG_STATUS   = 3'd2,
        REG_OAM_ADDR = 3'd3,
        REG_OAM_DATA = 3'd4,
        REG_SCROLL   = 3'd5,
        REG_ADDR     = 3'd6,
        REG_DATA     = 3'd7
    } ppu_reg_e;

    // two-dot slots inside each 8-dot tile fetch
    typedef enum logic [1:0] {
        FETCH_NAMETABLE  = 2'd0,
        FETCH_ATTRIBUTE  = 2'd1,
        FETCH_PATTERN_LO = 2'd2,
        FETCH_PATTERN_HI = 2'd3
    } fetch_phase_e;

    // frame timing
    localparam cycle_t    LAST_CYCLE          = 9'd340;
    localparam cycle_t    LAST_CYCLE_SHORT    = 9'd339;
    localparam cycle_t    SCROLL_RELOAD_CYCLE = 9'd320;
    localparam scanline_t VBLANK_LINE         = 9'd240;
    localparam scanline_t LAST_LINE           = 9'd260;
    // line -1 in 9-bit two's complement
    localparam scanline_t PRERENDER_LINE      = 9'd511;

    // address bits 13:8 of the palette window
    localparam logic [5:0] PALETTE_PAGE = 6'h3f;

    // data port address steps, picked by ctrl bit 2
    localparam int INC_ACROSS = 1;
    localparam int INC_DOWN   = 32;

endpackage

`default_nettype wire

// ==== src/ppu_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_timing import ppu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ce,
    input  logic      rendering_enabled,
    input  logic      status_read,
    output scanline_t scanline,
    output cycle_t    cycle,
    output logic      in_vblank
);

    logic odd_frame;
    logic short_line;
    logic line_end;
    logic frame_end;

    // odd frames drop one dot from the pre-render line while rendering
    assign short_line = odd_frame && rendering_enabled && (scanline == PRERENDER_LINE);
    assign line_end   = short_line ? (cycle == LAST_CYCLE_SHORT) : (cycle == LAST_CYCLE);
    assign frame_end  = line_end && (scanline == LAST_LINE);

    // dot and line counters
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle     <= '0;
            scanline  <= '0;
            odd_frame <= 1'b0;
        end else if (ce) begin
            cycle <= line_end ? '0 : cycle + 9'd1;
            if (line_end) begin
                // 260 jumps to the all-ones pre-render line, which wraps to 0
                scanline <= frame_end ? PRERENDER_LINE : scanline + 9'd1;
            end
            if (frame_end) begin
                odd_frame <= ~odd_frame;
            end
        end
    end

    // vblank flag, the cpu sees it through status bit 7 and nmi
    always_ff @(posedge clk) begin
        if (reset) begin
            in_vblank <= 1'b1;
        end else if (ce) begin
            if (line_end && (scanline == VBLANK_LINE)) begin
                in_vblank <= 1'b1;
            end else if (frame_end || status_read) begin
                // a status read acknowledges the flag
                in_vblank <= 1'b0;
            end
        end
    end

    // the dot counter always wraps at the line end
    a_cycle_range: assert property (
        @(posedge clk) disable iff (reset)
        cycle <= LAST_CYCLE
    );

    // no line number exists between 260 and the pre-render line
    a_scanline_range: assert property (
        @(posedge clk) disable iff (reset)
        !((scanline > LAST_LINE) && (scanline < PRERENDER_LINE))
    );

endmodule

`default_nettype wire

// ==== src/ppu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_regs import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  ppu_reg_e   ain,
    input  byte_t      din,
    input  logic       read,
    input  logic       write,
    input  logic       in_vblank,
    output byte_t      dout,
    output logic       status_read,
    output logic       nmi,
    output logic       rendering_enabled,
    output logic [1:0] nametable_sel,
    output logic       bg_pattern_sel,
    output scroll_t    scroll_x,
    output scroll_t    scroll_y,
    output logic       cpu_vram_access,
    output logic       cpu_vram_read,
    output vram_addr_t cpu_vram_addr,
    output logic       vram_w,
    output byte_t      vram_dout,
    output logic       pal_we,
    output pal_index_t pal_addr,
    output color_t     pal_data
);

    byte_t       ctrl;
    byte_t       mask;
    // {x, y}, first write lands in the upper byte
    logic [15:0] scroll;
    // data port address, first write lands in the upper byte
    logic [15:0] addr;
    // write toggle shared by scroll and addr
    logic        w;
    logic        data_access;
    logic        data_write;
    logic        pal_page;

    assign data_access = (ain == REG_DATA) && (read || write);
    assign data_write  = (ain == REG_DATA) && write;
    assign pal_page    = (addr[13:8] == PALETTE_PAGE);
    assign status_read = ce && read && (ain == REG_STATUS);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl   <= '0;
            mask   <= '0;
            scroll <= '0;
            addr   <= '0;
            w      <= 1'b0;
        end else if (ce) begin
            if (write) begin
                case (ain)
                    REG_CTRL: ctrl <= din;
                    REG_MASK: mask <= din;
                    REG_SCROLL: begin
                        if (!w) begin
                            scroll[15:8] <= din;
                        end else begin
                            scroll[7:0] <= din;
                        end
                        w <= ~w;
                    end
                    REG_ADDR: begin
                        if (!w) begin
                            addr[15:8] <= din;
                        end else begin
                            addr[7:0] <= din;
                        end
                        w <= ~w;
                    end
                    default: ;
                endcase
            end
            if (status_read) begin
                w <= 1'b0;
            end
            // step across a row or down a column of the nametable
            if (data_access) begin
                addr <= addr + 16'(ctrl[2] ? INC_DOWN : INC_ACROSS);
            end
        end
    end

    // only the vblank bit of status is modelled
    assign dout = (read && (ain == REG_STATUS)) ? {in_vblank, 7'd0} : 8'd0;
    assign nmi  = in_vblank && ctrl[7];

    // mask bits 3 and 4 enable background and sprites
    assign rendering_enabled = (mask[4:3] != 2'b00);
    assign nametable_sel     = ctrl[1:0];
    assign bg_pattern_sel    = ctrl[4];
    assign scroll_x          = scroll[15:8];
    assign scroll_y          = scroll[7:0];

    assign cpu_vram_access = data_access;
    assign cpu_vram_read   = read && (ain == REG_DATA);
    assign cpu_vram_addr   = addr[13:0];

    // palette page writes stay inside the ppu
    assign vram_w    = data_write && !pal_page;
    assign vram_dout = din;
    assign pal_we    = data_write && pal_page;
    assign pal_addr  = addr[4:0];
    assign pal_data  = din[5:0];

    a_one_write_target: assert property (
        @(posedge clk) disable iff (reset)
        !(vram_w && pal_we)
    );

endmodule

`default_nettype wire

// ==== src/ppu_palette.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_palette import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  logic       pal_we,
    input  pal_index_t pal_addr,
    input  color_t     pal_data,
    input  pal_index_t pixel_index,
    output color_t     color
);

    // 0-15 background, 16-31 sprites
    color_t mem [32];
    logic   mirror_slot;

    // entries 4, 8 and c of each half alias the backdrop
    assign mirror_slot = (pal_addr[1:0] == 2'b00) && (pal_addr[3:2] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= '0;
            end
        end else if (ce && pal_we && !mirror_slot) begin
            mem[pal_addr] <= pal_data;
        end
    end

    // index 0 gives the backdrop color
    assign color = mem[pixel_index];

endmodule

`default_nettype wire

// ==== src/ppu_background.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_background import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  scanline_t  scanline,
    input  cycle_t     cycle,
    input  logic       in_vblank,
    input  logic       rendering_enabled,
    input  logic [1:0] nametable_sel,
    input  logic       bg_pattern_sel,
    input  scroll_t    scroll_x,
    input  scroll_t    scroll_y,
    input  logic       cpu_vram_access,
    input  logic       cpu_vram_read,
    input  vram_addr_t cpu_vram_addr,
    input  byte_t      vram_din,
    output vram_addr_t vram_a,
    output logic       vram_r,
    output pal_index_t pixel_index
);

    logic         render_active;
    // dot - 1 so each tile slot starts at a multiple of 8
    cycle_t       dot;
    fetch_phase_e phase;
    logic         tile_end;
    logic         shift_window;
    logic [4:0]   coarse_x;
    scroll_t      y_pos;
    byte_t        nt_byte;
    logic [1:0]   at_bits;
    byte_t        pat_lo;
    logic [15:0]  pat_lo_sr;
    logic [15:0]  pat_hi_sr;
    logic [15:0]  att_lo_sr;
    logic [15:0]  att_hi_sr;
    vram_addr_t   fetch_addr;
    bg_pixel_t    bg_pixel;

    // leftmost pixel is the msb of a pattern byte
    function automatic byte_t bit_rev(input byte_t b);
        byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    assign render_active = rendering_enabled && !in_vblank && (scanline != VBLANK_LINE);
    assign dot           = cycle - 9'd1;
    assign phase         = fetch_phase_e'(dot[2:1]);
    assign tile_end      = (cycle[2:0] == 3'd0);
    assign shift_window  = (cycle >= 9'd1) && (cycle <= 9'd336);

    // coarse x and y scroll counters, no nametable rollover
    always_ff @(posedge clk) begin
        if (reset) begin
            coarse_x <= '0;
            y_pos    <= '0;
        end else if (ce && render_active) begin
            if (cycle == SCROLL_RELOAD_CYCLE) begin
                coarse_x <= scroll_x[7:3];
                // pre-render line restarts the vertical position too
                if (scanline == PRERENDER_LINE) begin
                    y_pos <= scroll_y;
                end
            end else if (tile_end && shift_window) begin
                coarse_x <= coarse_x + 5'd1;
            end
            if (cycle == 9'd251) begin
                y_pos <= y_pos + 8'd1;
            end
        end
    end

    always_comb begin
        case (phase)
            FETCH_NAMETABLE:  fetch_addr = {2'b10, nametable_sel, y_pos[7:3], coarse_x};
            // attribute table sits at offset 0x3c0 of the nametable
            FETCH_ATTRIBUTE:  fetch_addr = {2'b10, nametable_sel, 4'b1111, y_pos[7:5],
                                            coarse_x[4:2]};
            FETCH_PATTERN_LO: fetch_addr = {1'b0, bg_pattern_sel, nt_byte, 1'b0, y_pos[2:0]};
            default:          fetch_addr = {1'b0, bg_pattern_sel, nt_byte, 1'b1, y_pos[2:0]};
        endcase
    end

    // cpu data port owns the bus for its cycle
    assign vram_a = cpu_vram_access ? cpu_vram_addr : fetch_addr;
    // render reads go out on odd dots, data returns on the even dot
    assign vram_r = cpu_vram_read || (render_active && cycle[0]);

    always_ff @(posedge clk) begin
        if (ce && render_active) begin
            case (cycle[2:0])
                3'd2: nt_byte <= vram_din;
                // quadrant of the 32x32 attribute block
                3'd4: at_bits <= vram_din[{y_pos[4], coarse_x[1], 1'b0} +: 2];
                3'd6: pat_lo  <= vram_din;
                default: ;
            endcase
            if (shift_window) begin
                if (tile_end) begin
                    // pattern high byte arrives now, load the next tile into the top half
                    pat_lo_sr <= {bit_rev(pat_lo), pat_lo_sr[8:1]};
                    pat_hi_sr <= {bit_rev(vram_din), pat_hi_sr[8:1]};
                    att_lo_sr <= {{8{at_bits[0]}}, att_lo_sr[8:1]};
                    att_hi_sr <= {{8{at_bits[1]}}, att_hi_sr[8:1]};
                end else begin
                    pat_lo_sr <= {1'b0, pat_lo_sr[15:1]};
                    pat_hi_sr <= {1'b0, pat_hi_sr[15:1]};
                    att_lo_sr <= {1'b0, att_lo_sr[15:1]};
                    att_hi_sr <= {1'b0, att_hi_sr[15:1]};
                end
            end
        end
    end

    assign bg_pixel    = {att_hi_sr[0], att_lo_sr[0], pat_hi_sr[0], pat_lo_sr[0]};
    // backdrop while idle
    assign pixel_index = render_active ? {1'b0, bg_pixel} : '0;

    // even dots carry only cpu reads, the fetch data comes back there
    a_read_on_odd: assert property (
        @(posedge clk) disable iff (reset)
        vram_r && !cycle[0] |-> cpu_vram_read
    );

endmodule

`default_nettype wire

// ==== src/ppu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppu_top import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    // cpu register port
    input  ppu_reg_e   ain,
    input  byte_t      din,
    input  logic       read,
    input  logic       write,
    output byte_t      dout,
    // video memory
    output vram_addr_t vram_a,
    output logic       vram_r,
    output logic       vram_w,
    output byte_t      vram_dout,
    input  byte_t      vram_din,
    // video out and frame position
    output color_t     color,
    output logic       nmi,
    output scanline_t  scanline,
    output cycle_t     cycle
);

    logic       in_vblank;
    logic       status_read;
    logic       rendering_enabled;
    logic [1:0] nametable_sel;
    logic       bg_pattern_sel;
    scroll_t    scroll_x;
    scroll_t    scroll_y;
    logic       cpu_vram_access;
    logic       cpu_vram_read;
    vram_addr_t cpu_vram_addr;
    logic       pal_we;
    pal_index_t pal_addr;
    color_t     pal_data;
    pal_index_t pixel_index;

    // port names match the nets one to one
    ppu_timing i_timing (
        .*
    );

    ppu_regs i_regs (
        .*
    );

    ppu_palette i_palette (
        .*
    );

    ppu_background i_background (
        .*
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vram_model import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // dut video memory port
    input  vram_addr_t vram_a,
    input  logic       vram_r,
    input  logic       vram_w,
    input  byte_t      vram_dout,
    output byte_t      vram_din,
    // observed dut outputs and cpu bus
    input  scanline_t  scanline,
    input  cycle_t     cycle,
    input  color_t     color,
    input  logic       nmi,
    input  ppu_reg_e   ain,
    input  byte_t      din,
    input  byte_t      dout,
    input  logic       read,
    input  logic       write,
    // check enables and expected values from the testbench
    input  logic       chk_frame,
    input  logic       chk_nmi,
    input  logic       chk_data,
    input  logic       chk_pal,
    input  logic       chk_color,
    input  logic       chk_bg,
    input  logic       chk_skip,
    input  logic       bg_mode,
    input  vram_addr_t exp_addr,
    input  logic       exp_vbl,
    input  color_t     exp_color,
    input  logic [1:0] exp_nt,
    input  byte_t      tile_byte,
    output int         mismatches
);

    byte_t mem [16384];
    // parity of the frame in progress, toggles at the end of line 260
    logic  ref_odd;

    initial begin
        mismatches = 0;
        // fill depends on every address bit
        for (int i = 0; i < 16384; i++) begin
            mem[i] = byte_t'(i[7:0] ^ {2'b00, i[13:8]});
        end
    end

    // line after a given line in the frame sequence
    function automatic scanline_t next_line(input scanline_t l);
        if (l == 9'd260) begin
            return 9'd511;
        end else if (l == 9'd511) begin
            return 9'd0;
        end
        return l + 9'd1;
    endfunction

    // fixed background scene: tile T, attribute 0, solid pattern
    function automatic byte_t scene_byte(input vram_addr_t a);
        if (!a[13]) begin
            return 8'hff;
        end else if (a[9:6] == 4'b1111) begin
            return 8'h00;
        end
        return tile_byte;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH t=%0t %s", $time, msg);
        mismatches++;
    endtask

    // data one cycle after the read strobe
    always @(posedge clk) begin
        if (reset) begin
            vram_din <= '0;
        end else begin
            if (vram_r) begin
                vram_din <= bg_mode ? scene_byte(vram_a) : mem[vram_a];
            end
            if (vram_w) begin
                mem[vram_a] <= vram_dout;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ref_odd <= 1'b0;
        end else if (scanline == 9'd260 && cycle == 9'd340) begin
            ref_odd <= ~ref_odd;
        end
    end

    a_cycle_incr: assert property (@(posedge clk) disable iff (reset)
        chk_frame && cycle != 9'd340 |=> cycle == $past(cycle) + 9'd1)
        else report_mismatch("cycle did not advance by one");

    a_cycle_wrap: assert property (@(posedge clk) disable iff (reset)
        chk_frame && cycle == 9'd340 |=> cycle == 9'd0 &&
        scanline == next_line($past(scanline)))
        else report_mismatch("bad line end wrap");

    // no reads while idle, render reads on odd dots of line 0
    a_read_strobe: assert property (@(posedge clk) disable iff (reset)
        chk_frame || (chk_bg && scanline == 9'd0 && cycle <= 9'd256) |->
        vram_r == (chk_bg && cycle[0]))
        else report_mismatch($sformatf("read strobe %0b at cycle %0d", vram_r, cycle));

    a_nmi_rise: assert property (@(posedge clk) disable iff (reset)
        chk_nmi && scanline == 9'd240 && cycle == 9'd340 |-> !nmi ##1 nmi)
        else report_mismatch("nmi not rising at line 240 end");

    a_status_bit: assert property (@(posedge clk) disable iff (reset)
        chk_nmi && read && ain == REG_STATUS |-> dout[7] == exp_vbl)
        else report_mismatch($sformatf("status bit 7 is %0b", dout[7]));

    a_nmi_fall: assert property (@(posedge clk) disable iff (reset)
        chk_nmi && read && ain == REG_STATUS |=> !nmi)
        else report_mismatch("nmi still high after status read");

    a_data_write: assert property (@(posedge clk) disable iff (reset)
        chk_data && write && ain == REG_DATA |->
        vram_w && vram_a == exp_addr && vram_dout == din)
        else report_mismatch($sformatf("data write at %h, want %h", vram_a, exp_addr));

    a_pal_no_vram: assert property (@(posedge clk) disable iff (reset)
        chk_pal && write && ain == REG_DATA |-> !vram_w)
        else report_mismatch("palette write reached video memory");

    a_color: assert property (@(posedge clk) disable iff (reset)
        chk_color |-> color == exp_color)
        else report_mismatch($sformatf("color %h, want %h", color, exp_color));

    a_nt_fetch: assert property (@(posedge clk) disable iff (reset)
        chk_bg && scanline == 9'd0 && cycle[2:0] == 3'd1 && cycle <= 9'd256 |->
        vram_a[13:10] == {2'b10, exp_nt})
        else report_mismatch($sformatf("nametable fetch at %h", vram_a));

    // both pattern fetches, cycle mod 8 of 5 and 7
    a_pat_fetch: assert property (@(posedge clk) disable iff (reset)
        chk_bg && scanline == 9'd0 && cycle[2] && cycle[0] && cycle <= 9'd256 |->
        vram_a[11:4] == tile_byte)
        else report_mismatch($sformatf("pattern fetch at %h", vram_a));

    a_bg_color: assert property (@(posedge clk) disable iff (reset)
        chk_bg && scanline == 9'd0 && cycle >= 9'd17 && cycle <= 9'd256 |-> color == exp_color)
        else report_mismatch($sformatf("pixel color %h, want %h", color, exp_color));

    // short pre-render line only on odd frames
    a_odd_skip: assert property (@(posedge clk) disable iff (reset)
        chk_skip && scanline == 9'd511 && cycle == 9'd339 |=> (cycle == 9'd0) == ref_odd)
        else report_mismatch("pre-render length wrong for frame parity");

endmodule

`default_nettype wire

// ==== testbench/tb_ppu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ppu import ppu_pkg::*;;

    localparam int FRAME_CYCLES = 262 * 341;

    logic clk, reset, ce, read, write;
    ppu_reg_e ain;
    byte_t din, dout, vram_dout, vram_din, tile_byte;
    vram_addr_t vram_a, exp_addr, a;
    logic vram_r, vram_w, nmi, exp_vbl, bg_mode;
    color_t color, exp_color;
    scanline_t scanline;
    cycle_t cycle;
    logic chk_frame, chk_nmi, chk_data, chk_pal, chk_color, chk_bg, chk_skip;
    logic [1:0] exp_nt;
    logic pat_sel;
    int mismatches, seen, tests_failed, tests_run;
    int unsigned seed;

    ppu_top i_dut (.*);

    tb_vram_model i_vram (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one cpu bus write, called at 2 ns after an edge
    task automatic cpu_write(input ppu_reg_e r, input byte_t d);
        ain = r;
        din = d;
        write = 1'b1;
        @(posedge clk);
        #2;
        write = 1'b0;
    endtask

    task automatic cpu_read(input ppu_reg_e r);
        ain = r;
        read = 1'b1;
        @(posedge clk);
        #2;
        read = 1'b0;
    endtask

    // status read clears the write toggle first
    task automatic set_vram_addr(input vram_addr_t va);
        cpu_read(REG_STATUS);
        cpu_write(REG_ADDR, {2'b00, va[13:8]});
        cpu_write(REG_ADDR, va[7:0]);
    endtask

    task automatic wait_for_pos(input scanline_t l, input cycle_t c);
        while (!(scanline == l && cycle == c)) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (mismatches == seen) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: FAILED", tests_run, name);
            tests_failed++;
        end
        seen = mismatches;
    endtask

    // three frames of tests plus waits for frame positions
    initial begin
        repeat (6 * FRAME_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within six frames");
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = 32'hc7a7;
        void'($urandom(seed));
        {reset, ce, read, write, bg_mode, exp_vbl} = 6'b110000;
        {chk_frame, chk_nmi, chk_data, chk_pal, chk_color, chk_bg, chk_skip} = '0;
        ain = REG_CTRL;
        {din, tile_byte, exp_addr, exp_color, exp_nt} = '0;
        {seen, tests_failed, tests_run} = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // frame counters with rendering off
        chk_frame = 1'b1;
        wait_for_pos(9'd511, 9'd0);
        wait_for_pos(9'd0, 9'd1);
        chk_frame = 1'b0;
        finish_test("frame timing");

        chk_nmi = 1'b1;
        cpu_write(REG_CTRL, 8'h80);
        wait_for_pos(9'd241, 9'd4);
        exp_vbl = 1'b1;
        cpu_read(REG_STATUS);
        exp_vbl = 1'b0;
        cpu_read(REG_STATUS);
        chk_nmi = 1'b0;
        finish_test("vblank and nmi");

        chk_data = 1'b1;
        for (int inc = 0; inc < 2; inc++) begin
            cpu_write(REG_CTRL, inc ? 8'h84 : 8'h80);
            a = vram_addr_t'($urandom % 32'h3e00);
            set_vram_addr(a);
            exp_addr = a;
            cpu_write(REG_DATA, byte_t'($urandom));
            exp_addr = a + (inc ? 14'd32 : 14'd1);
            cpu_write(REG_DATA, byte_t'($urandom));
        end
        chk_data = 1'b0;
        cpu_write(REG_CTRL, 8'h80);
        finish_test("data port writes");

        chk_pal = 1'b1;
        set_vram_addr(14'h3f00);
        exp_color = color_t'($urandom);
        cpu_write(REG_DATA, {2'b00, exp_color});
        chk_color = 1'b1;
        set_vram_addr(14'h3f04);
        cpu_write(REG_DATA, {2'b00, ~exp_color});
        @(posedge clk);
        #2;
        {chk_pal, chk_color} = 2'b00;
        finish_test("palette writes");

        // solid tile T through palette entry 3
        tile_byte = byte_t'($urandom);
        exp_nt = 2'($urandom);
        pat_sel = 1'($urandom);
        bg_mode = 1'b1;
        set_vram_addr(14'h3f03);
        exp_color = color_t'($urandom);
        cpu_write(REG_DATA, {2'b00, exp_color});
        cpu_write(REG_CTRL, {3'b100, pat_sel, 2'b00, exp_nt});
        cpu_write(REG_MASK, 8'h08);
        chk_bg = 1'b1;
        wait_for_pos(9'd1, 9'd0);
        chk_bg = 1'b0;
        finish_test("background fetch");

        chk_skip = 1'b1;
        for (int f = 0; f < 2; f++) begin
            wait_for_pos(9'd511, 9'd0);
            wait_for_pos(9'd0, 9'd1);
        end
        chk_skip = 1'b0;
        finish_test("odd frame skip");

        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, mismatches);
        if (tests_failed == 0 && mismatches == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/ppu_pkg.sv
src/ppu_timing.sv
src/ppu_regs.sv
src/ppu_palette.sv
src/ppu_background.sv
src/ppu_top.sv
testbench/tb_vram_model.sv
testbench/tb_ppu.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the ppu testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_ppu \
    -o tb_ppu > build.log 2>&1 \
    && ./obj_dir/tb_ppu > sim.log 2>&1

grep -q "^sim passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL (see build.log and sim.log)"; exit 1; }
